/* Makefile */
# Verilator simulation of the object layer

VERILATOR ?= verilator
TOP       ?= obj_video_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Testbench passed

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR)

/* filelist.f */
+incdir+tests
logic/video_pkg.sv
logic/obj_pkg.sv
logic/video_timing.sv
logic/sync_ram.sv
logic/obj_line_fetch.sv
logic/obj_shifter.sv
logic/obj_video_top.sv
tests/obj_video_tb.sv

/* logic/obj_line_fetch.sv */
// Object column prefetch
`timescale 1ns/100ps
`default_nettype none

module obj_line_fetch #(
    parameter int H_TOTAL_COLS = 40,
    parameter int V_TOTAL      = 262
) (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           col_start,
    input  video_pkg::hpos_t    hpos,
    input  video_pkg::vpos_t    vpos,
    output obj_pkg::desc_addr_t desc_raddr,
    input  obj_pkg::obj_desc_t  desc_rdata,
    output obj_pkg::rom_addr_t  rom_raddr,
    input  obj_pkg::obj_planes_t rom_rdata,
    output obj_pkg::obj_desc_t  next_desc,
    output obj_pkg::obj_planes_t next_planes
);
    import video_pkg::*;
    import obj_pkg::*;

    localparam int COL_W = $bits(hpos_t) - COL_SHIFT;

    typedef enum logic [1:0] {
        S_IDLE,     // Results held for the shifter
        S_DESC,     // Descriptor on desc_rdata
        S_ROM       // Plane pair on rom_rdata
    } state_t;

    state_t          state;
    logic            primed;    // First column start seen
    logic [COL_W-1:0] cur_col;
    logic [COL_W-1:0] nxt_col;
    logic            at_last;
    vpos_t           nxt_line;
    obj_desc_t       desc_q;

    assign cur_col  = hpos[$bits(hpos_t)-1:COL_SHIFT];
    assign at_last  = cur_col == COL_W'(H_TOTAL_COLS - 1);
    assign nxt_col  = at_last ? '0 : cur_col + 1'b1;   // Col 0 prefetched in hblank
    assign nxt_line = (vpos == vpos_t'(V_TOTAL - 1)) ? '0 : vpos + 1'b1;

    // Column ahead of the beam; before the raster starts, the column under it
    assign desc_raddr.col  = col_start ? nxt_col[4:0] : cur_col[4:0];
    assign desc_raddr.slot = (col_start && at_last) ? nxt_line[3:0] : vpos[3:0];

    // Second read depends on the first
    assign rom_raddr.code = desc_rdata.code;
    assign rom_raddr.row  = desc_rdata.row;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= S_IDLE;
            primed <= 1'b0;
        end else if (col_start) begin
            state  <= S_DESC;
            primed <= 1'b1;
        end else begin
            case (state)
                S_IDLE:  if (!primed) state <= S_DESC;     // Keep column 0 fresh
                S_DESC:  state <= S_ROM;
                S_ROM:   state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_DESC) begin
            desc_q <= desc_rdata;
        end
        if (state == S_ROM) begin   // Stable until next column start
            next_desc   <= desc_q;
            next_planes <= rom_rdata;
        end
    end

endmodule

`default_nettype wire

/* logic/obj_pkg.sv */
// Object table and ROM types
`default_nettype none

package obj_pkg;

    // One descriptor per column of each line slot
    typedef struct packed {
        logic [7:0] code;       // Object number in graphics ROM
        logic [3:0] row;        // Row within the object
        logic [2:0] pal;        // Zero blanks the whole column
        logic       hflip;      // Set for LSB-last order
    } obj_desc_t;

    // Both bit-planes of one object row, 16 half-pixels each
    typedef struct packed {
        logic [15:0] plane1;    // High bit of the pixel value
        logic [15:0] plane0;    // Low bit
    } obj_planes_t;

    // Descriptor table address
    // 16 line slots of 32 columns
    typedef struct packed {
        logic [3:0] slot;       // Line modulo 16
        logic [4:0] col;        // Column on that line
    } desc_addr_t;

    // Graphics ROM address, one plane pair per word
    typedef struct packed {
        logic [7:0] code;
        logic [3:0] row;
    } rom_addr_t;

endpackage

`default_nettype wire

/* logic/obj_shifter.sv */
// Object pixel shifter
`timescale 1ns/100ps
`default_nettype none

module obj_shifter (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            half_cen,
    input  wire logic            col_start,
    input  video_pkg::hpos_t     hpos,
    input  video_pkg::vpos_t     vpos,
    input  wire logic            hb,
    input  wire logic            vb,
    input  obj_pkg::obj_desc_t   next_desc,
    input  obj_pkg::obj_planes_t next_planes,
    output video_pkg::obj_pixel_t pix
);
    import video_pkg::*;
    import obj_pkg::*;

    logic [15:0] sr1;           // Plane 1 shift register
    logic [15:0] sr0;           // Plane 0 shift register
    logic        flip_q;        // Flip latched at load
    logic [2:0]  pal_q;         // Palette latched at load

    obj_planes_t src;           // Planes feeding this tick
    logic        src_flip;
    logic [2:0]  src_pal;
    logic [1:0]  bit_val;

    logic        valid_q;
    hpos_t       hpos_q;
    vpos_t       vpos_q;
    logic [2:0]  out_pal;
    logic [1:0]  out_val;

    // At the column boundary the new column's half-pixel 0 is taken straight
    // from the fetch outputs, later ticks come from the shift registers
    always_comb begin
        if (col_start) begin
            src      = next_planes;
            src_flip = next_desc.hflip;
            src_pal  = next_desc.pal;
        end else begin
            src.plane1 = sr1;
            src.plane0 = sr0;
            src_flip   = flip_q;
            src_pal    = pal_q;
        end
        // Flip reads from the top end
        bit_val = src_flip ? {src.plane1[15], src.plane0[15]}
                           : {src.plane1[0],  src.plane0[0]};
    end

    // Load and shift share one path, the register keeps what is left
    always_ff @(posedge clk) begin
        if (half_cen) begin
            sr1 <= src_flip ? {src.plane1[14:0], 1'b0} : {1'b0, src.plane1[15:1]};
            sr0 <= src_flip ? {src.plane0[14:0], 1'b0} : {1'b0, src.plane0[15:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flip_q <= 1'b0;
            pal_q  <= '0;
        end else if (col_start) begin
            flip_q <= next_desc.hflip;
            pal_q  <= next_desc.pal;
        end
    end

    // Valid is a one-clock pulse per visible tick
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= half_cen && !hb && !vb;
        end
    end

    // Pixel payload with its position tag
    always_ff @(posedge clk) begin
        if (rst) begin
            hpos_q <= '0;       // Tag starts at the origin
            vpos_q <= '0;
        end else if (half_cen) begin
            hpos_q  <= hpos;
            vpos_q  <= vpos;
            out_pal <= src_pal;
            out_val <= (src_pal == 3'd0 || vb) ? 2'b00 : bit_val;  // Black palette or vblank
        end
    end

    assign pix.valid = valid_q;
    assign pix.hpos  = hpos_q;
    assign pix.vpos  = vpos_q;
    assign pix.pal   = out_pal;
    assign pix.val   = out_val;

endmodule

`default_nettype wire

/* logic/obj_video_top.sv */
// Object layer video top level
`timescale 1ns/100ps
`default_nettype none

module obj_video_top #(
    parameter int H_VISIBLE_COLS = 32,
    parameter int H_TOTAL_COLS   = 40,
    parameter int V_VISIBLE      = 224,
    parameter int V_TOTAL        = 262,
    parameter int CLK_PER_HALF   = 2
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             run,
    input  wire logic             desc_we,
    input  obj_pkg::desc_addr_t   desc_addr,
    input  obj_pkg::obj_desc_t    desc_data,
    input  wire logic             rom_we,
    input  obj_pkg::rom_addr_t    rom_addr,
    input  obj_pkg::obj_planes_t  rom_data,
    output video_pkg::obj_pixel_t pix,
    output logic                  hb,
    output logic                  vb
);
    import video_pkg::*;
    import obj_pkg::*;

    logic        half_cen;
    logic        col_start;
    hpos_t       hpos;
    vpos_t       vpos;

    desc_addr_t  desc_raddr;
    obj_desc_t   desc_rdata;
    rom_addr_t   rom_raddr;
    obj_planes_t rom_rdata;
    obj_desc_t   next_desc;     // Column ahead of the beam
    obj_planes_t next_planes;

    video_timing #(
        .H_VISIBLE_COLS (H_VISIBLE_COLS),
        .H_TOTAL_COLS   (H_TOTAL_COLS),
        .V_VISIBLE      (V_VISIBLE),
        .V_TOTAL        (V_TOTAL),
        .CLK_PER_HALF   (CLK_PER_HALF)
    ) u_timing (
        .clk, .rst, .run,
        .half_cen, .col_start, .hpos, .vpos, .hb, .vb
    );

    // Descriptor table, written by the host
    sync_ram #(
        .word_t (obj_desc_t),
        .ADDR_W ($bits(desc_addr_t))
    ) desc_ram (
        .clk,
        .we    (desc_we),
        .waddr (desc_addr),
        .wdata (desc_data),
        .raddr (desc_raddr),
        .rdata (desc_rdata)
    );

    // Graphics ROM image
    sync_ram #(
        .word_t (obj_planes_t),
        .ADDR_W ($bits(rom_addr_t))
    ) rom (
        .clk,
        .we    (rom_we),
        .waddr (rom_addr),
        .wdata (rom_data),
        .raddr (rom_raddr),
        .rdata (rom_rdata)
    );

    obj_line_fetch #(
        .H_TOTAL_COLS (H_TOTAL_COLS),
        .V_TOTAL      (V_TOTAL)
    ) u_fetch (
        .clk, .rst, .col_start, .hpos, .vpos,
        .desc_raddr, .desc_rdata, .rom_raddr, .rom_rdata,
        .next_desc, .next_planes
    );

    obj_shifter u_shifter (
        .clk, .rst, .half_cen, .col_start,
        .hpos, .vpos, .hb, .vb,
        .next_desc, .next_planes,
        .pix
    );

endmodule

`default_nettype wire

/* logic/sync_ram.sv */
// Synchronous block memory
`timescale 1ns/100ps
`default_nettype none

module sync_ram #(
    parameter type word_t = logic [15:0],
    parameter int  ADDR_W = 8
) (
    input  wire logic              clk,
    input  wire logic              we,
    input  wire logic [ADDR_W-1:0] waddr,
    input  word_t                  wdata,
    input  wire logic [ADDR_W-1:0] raddr,
    output word_t                  rdata
);

    localparam int DEPTH = 2 ** ADDR_W;

    // Contents are left as loaded, never cleared
    word_t mem [DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read, old word on a same-address write
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

/* logic/video_pkg.sv */
// Raster position and pixel types
`default_nettype none

package video_pkg;

    // Half-pixels in one 8-pixel column
    localparam int COL_HALF  = 16;
    localparam int COL_SHIFT = 4;       // log2 of COL_HALF

    // Horizontal position, counted in half-pixels
    typedef logic [9:0] hpos_t;

    // Line number inside the frame
    typedef logic [8:0] vpos_t;

    // One object-layer pixel per half-pixel tick
    // Position tag lets the layer mixer line it up with the background
    typedef struct packed {
        logic       valid;      // High only for visible ticks
        hpos_t      hpos;       // Half-pixel that produced it
        vpos_t      vpos;       // Line that produced it
        logic [2:0] pal;        // Palette of the column
        logic [1:0] val;        // {plane1, plane0}, 0 is transparent
    } obj_pixel_t;

endpackage

`default_nettype wire

/* logic/video_timing.sv */
// Raster timing generator
`timescale 1ns/100ps
`default_nettype none

module video_timing #(
    parameter int H_VISIBLE_COLS = 32,
    parameter int H_TOTAL_COLS   = 40,
    parameter int V_VISIBLE      = 224,
    parameter int V_TOTAL        = 262,
    parameter int CLK_PER_HALF   = 2
) (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          run,
    output logic               half_cen,
    output logic               col_start,
    output video_pkg::hpos_t   hpos,
    output video_pkg::vpos_t   vpos,
    output logic               hb,
    output logic               vb
);
    import video_pkg::*;

    localparam int CEN_W = (CLK_PER_HALF > 1) ? $clog2(CLK_PER_HALF) : 1;

    logic [CEN_W-1:0] cen_cnt;  // Clocks into the current half-pixel
    logic             h_wrap;
    logic             v_wrap;
    hpos_t            h_next;
    vpos_t            v_next;

    assign h_wrap = hpos == hpos_t'(H_TOTAL_COLS * COL_HALF - 1);   // Last half-pixel of line
    assign v_wrap = vpos == vpos_t'(V_TOTAL - 1);                   // Last line of frame
    assign h_next = h_wrap ? '0 : hpos + 1'b1;
    assign v_next = v_wrap ? '0 : vpos + 1'b1;

    // First half-pixel of each column
    assign col_start = half_cen && (hpos[COL_SHIFT-1:0] == '0);

    always_ff @(posedge clk) begin
        if (rst || !run) begin      // Held at origin until run
            cen_cnt  <= '0;
            half_cen <= 1'b0;
            hpos     <= '0;
            vpos     <= '0;
            hb       <= 1'b0;
            vb       <= 1'b0;
        end else begin
            // Divider, one tick per CLK_PER_HALF clocks
            if (cen_cnt == CEN_W'(CLK_PER_HALF - 1)) begin
                cen_cnt  <= '0;
                half_cen <= 1'b1;
            end else begin
                cen_cnt  <= cen_cnt + 1'b1;
                half_cen <= 1'b0;
            end
            // Counters move after the tick that used them
            if (half_cen) begin
                hpos <= h_next;
                hb   <= h_next >= hpos_t'(H_VISIBLE_COLS * COL_HALF);  // Blank follows position
                if (h_wrap) begin
                    vpos <= v_next;
                    vb   <= v_next >= vpos_t'(V_VISIBLE);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tests/obj_video_model.svh */
// Object layer reference model
`ifndef OBJ_VIDEO_MODEL_SVH
`define OBJ_VIDEO_MODEL_SVH

// Next LCG state, full 32-bit period
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// Descriptor table index for a raster position
// Slot is the line modulo 16, column is the half-pixel over 16
function automatic int desc_index(input int h, input int v);
    desc_addr_t a;
    a.slot = 4'(v % 16);
    a.col  = 5'(h / 16);
    return int'(a);
endfunction

// ROM index named by a descriptor
function automatic int rom_index(input obj_desc_t d);
    rom_addr_t r;
    r.code = d.code;
    r.row  = d.row;
    return int'(r);
endfunction

// Inside the visible window on both axes
function automatic bit pos_visible(input int h, input int v, input int h_vis, input int v_vis);
    return (h < h_vis) && (v < v_vis);
endfunction

// Pixel value for half-pixel k of a column
function automatic logic [1:0] model_val(
    input obj_desc_t   d,
    input obj_planes_t p,
    input int          k,
    input bit          in_vb
);
    int b;
    b = d.hflip ? 15 - k : k;           // Flip walks down from bit 15
    if (d.pal == 3'd0 || in_vb) begin   // Transparent
        return 2'b00;
    end
    return {p.plane1[b], p.plane0[b]};
endfunction

// Palette passes straight through
function automatic logic [2:0] model_pal(input obj_desc_t d);
    return d.pal;
endfunction

`endif

/* tests/obj_video_tb.sv */
// Object layer video testbench
`timescale 1ns/100ps
`default_nettype none

module obj_video_tb;
    import video_pkg::*;
    import obj_pkg::*;

    `include "obj_video_model.svh"

    // Short raster
    localparam int H_VISIBLE_COLS = 16;
    localparam int H_TOTAL_COLS   = 20;
    localparam int V_VISIBLE      = 8;
    localparam int V_TOTAL        = 10;
    localparam int CLK_PER_HALF   = 2;

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CLKS    = 10;
    localparam int H_VIS_HALF    = H_VISIBLE_COLS * 16;
    localparam int H_TOTAL_HALF  = H_TOTAL_COLS * 16;
    localparam int PIX_PER_FRAME = H_VIS_HALF * V_VISIBLE;
    localparam int FRAME_CLKS    = H_TOTAL_HALF * V_TOTAL * CLK_PER_HALF;
    localparam int LOAD_CLKS     = H_VISIBLE_COLS * V_TOTAL + 20;
    localparam int WATCHDOG_CLKS = RESET_CLKS + LOAD_CLKS + 2 * FRAME_CLKS + 1000;
    localparam logic [31:0] LCG_SEED = 32'h96b57ddd;

    // One column entry, repeated on every line slot
    typedef struct packed {
        logic [7:0] code;       // Base code, slot added on load
        logic [3:0] row;        // Base row, slot xored on load
        logic [2:0] pal;
        logic       hflip;
        logic       zero_exp;   // Whole column expected transparent
    } stim_t;

    stim_t stim_tbl [16] = '{
        '{8'h10, 4'h0, 3'd1, 1'b0, 1'b0},
        '{8'h21, 4'h3, 3'd2, 1'b1, 1'b0},
        '{8'h32, 4'h7, 3'd0, 1'b0, 1'b1},
        '{8'h43, 4'h1, 3'd3, 1'b0, 1'b0},
        '{8'h54, 4'hf, 3'd4, 1'b1, 1'b0},
        '{8'h65, 4'h8, 3'd5, 1'b0, 1'b0},
        '{8'h76, 4'h2, 3'd0, 1'b1, 1'b1},   // Flip ignored, palette zero
        '{8'h87, 4'hc, 3'd6, 1'b1, 1'b0},
        '{8'h98, 4'h4, 3'd7, 1'b0, 1'b0},
        '{8'ha9, 4'h9, 3'd1, 1'b1, 1'b0},
        '{8'hba, 4'h5, 3'd2, 1'b0, 1'b0},
        '{8'hcb, 4'he, 3'd0, 1'b0, 1'b1},
        '{8'hdc, 4'h6, 3'd3, 1'b1, 1'b0},
        '{8'hed, 4'ha, 3'd4, 1'b0, 1'b0},
        '{8'hfe, 4'hb, 3'd5, 1'b1, 1'b0},
        '{8'h0f, 4'hd, 3'd6, 1'b0, 1'b0}
    };

    logic        clk = 1'b0;
    logic        rst;
    logic        run;
    logic        desc_we;
    desc_addr_t  desc_addr;
    obj_desc_t   desc_data;
    logic        rom_we;
    rom_addr_t   rom_addr;
    obj_planes_t rom_data;
    obj_pixel_t  pix;
    logic        hb;
    logic        vb;

    obj_desc_t   shadow_desc [512];     // Copies of what the host wrote
    obj_planes_t shadow_rom  [4096];
    logic [31:0] lcg_state;

    int          errors;
    int          n_checked;
    int          n_plain;
    int          n_flip;
    int          n_zero;
    int          frame_idx;             // -1 until the first origin tick
    int          valid_count [3];
    int          exp_h;                 // Next tick's expected tag
    int          exp_v;
    bit          started;
    bit          vis;
    logic [18:0] prev_tag;

    obj_video_top #(
        .H_VISIBLE_COLS (H_VISIBLE_COLS),
        .H_TOTAL_COLS   (H_TOTAL_COLS),
        .V_VISIBLE      (V_VISIBLE),
        .V_TOTAL        (V_TOTAL),
        .CLK_PER_HALF   (CLK_PER_HALF)
    ) DUT (
        .clk, .rst, .run,
        .desc_we, .desc_addr, .desc_data,
        .rom_we, .rom_addr, .rom_data,
        .pix, .hb, .vb
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, expected);
            errors++;
        end
    endtask

    // Both tables, one descriptor and its ROM row per clock
    task automatic load_tables();
        stim_t       e;
        obj_desc_t   d;
        obj_planes_t w;
        int          di;
        for (int slot = 0; slot < V_TOTAL; slot++) begin
            for (int col = 0; col < H_VISIBLE_COLS; col++) begin
                e = stim_tbl[col];
                d.code  = e.code + 8'(slot);
                d.row   = e.row ^ 4'(slot);
                d.pal   = e.pal;
                d.hflip = e.hflip;
                lcg_state = lcg_next(lcg_state);
                w  = lcg_state;
                di = desc_index(col * 16, slot);
                @(posedge clk);
                desc_we   <= 1'b1;
                desc_addr <= desc_addr_t'(di);
                desc_data <= d;
                rom_we    <= 1'b1;
                rom_addr  <= rom_addr_t'(rom_index(d));
                rom_data  <= w;
                shadow_desc[di]          = d;
                shadow_rom[rom_index(d)] = w;
            end
        end
        @(posedge clk);
        desc_we <= 1'b0;
        rom_we  <= 1'b0;
    endtask

    // Value and palette of one pixel against the shadow tables
    task automatic check_pixel(input int h, input int v, input bit in_vb);
        obj_desc_t   d;
        obj_planes_t p;
        d = shadow_desc[desc_index(h, v)];
        p = shadow_rom[rom_index(d)];
        check_value("pix.val", 32'(pix.val), 32'(model_val(d, p, h % 16, in_vb)));
        check_value("pix.pal", 32'(pix.pal), 32'(model_pal(d)));
        if (stim_tbl[h / 16].zero_exp) begin
            check_value("pix.val in palette-zero column", 32'(pix.val), 32'd0);
        end
        if (!in_vb) begin
            if (d.pal == 3'd0) n_zero++;
            else if (d.hflip) n_flip++;
            else n_plain++;
        end
        n_checked++;
    endtask

    // Output monitor, sampled away from the driving edge
    always @(negedge clk) begin
        if (!started) begin
            check_value("pix.valid", 32'(pix.valid), 32'd0);   // Reset and idle
            check_value("pix.hpos", 32'(pix.hpos), 32'd0);
            check_value("pix.vpos", 32'(pix.vpos), 32'd0);
            check_value("hb", 32'(hb), 32'd0);
            check_value("vb", 32'(vb), 32'd0);
            prev_tag = {pix.hpos, pix.vpos};
        end else if (pix.valid || ({pix.hpos, pix.vpos} !== prev_tag)) begin
            prev_tag = {pix.hpos, pix.vpos};                    // New tick
            check_value("pix.hpos", 32'(pix.hpos), 32'(exp_h));
            check_value("pix.vpos", 32'(pix.vpos), 32'(exp_v));
            if (exp_h == 0 && exp_v == 0) frame_idx++;
            vis = pos_visible(exp_h, exp_v, H_VIS_HALF, V_VISIBLE);
            check_value("pix.valid", 32'(pix.valid), 32'(vis));
            if (pix.valid && frame_idx >= 0 && frame_idx < 3) valid_count[frame_idx]++;
            if (vis) begin
                check_pixel(exp_h, exp_v, 1'b0);
            end else if (exp_h < H_VIS_HALF) begin
                check_pixel(exp_h, exp_v, 1'b1);                // Vblank masks the value
            end
            if (exp_h == H_TOTAL_HALF - 1) begin                // Raster order
                exp_h = 0;
                exp_v = (exp_v == V_TOTAL - 1) ? 0 : exp_v + 1;
            end else begin
                exp_h++;
            end
            // Blank flags already describe the next position
            check_value("hb", 32'(hb), 32'(exp_h >= H_VIS_HALF));
            check_value("vb", 32'(vb), 32'(exp_v >= V_VISIBLE));
        end
    end

    // Two frames plus load time
    initial begin
        #(WATCHDOG_CLKS * CLK_PERIOD);
        $display("Timeout: the raster did not complete two frames in the expected time");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        rst       = 1'b1;
        run       = 1'b0;
        desc_we   = 1'b0;
        desc_addr = '0;
        desc_data = '0;
        rom_we    = 1'b0;
        rom_addr  = '0;
        rom_data  = '0;
        lcg_state = LCG_SEED;
        errors    = 0;
        n_checked = 0;
        n_plain   = 0;
        n_flip    = 0;
        n_zero    = 0;
        frame_idx = -1;
        exp_h     = 0;
        exp_v     = 0;
        started   = 1'b0;
        for (int f = 0; f < 3; f++) valid_count[f] = 0;

        repeat (RESET_CLKS) @(posedge clk);
        rst <= 1'b0;
        load_tables();
        repeat (8) @(posedge clk);      // Fetch unit settles on column 0
        run <= 1'b1;
        started = 1'b1;
        while (frame_idx < 2) @(posedge clk);   // Third frame has begun
        run <= 1'b0;

        for (int f = 0; f < 2; f++) begin
            check_value($sformatf("valid pixels in frame %0d", f), valid_count[f], PIX_PER_FRAME);
        end
        if (n_plain == 0 || n_flip == 0 || n_zero == 0) begin
            $display("Not every kind of descriptor reached the output");
            errors++;
        end
        $display("Summary: %0d pixels checked, %0d errors", n_checked, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
